// ==== test/frames_golden.txt ====
# name frames left right fire | expected score hearts gameOver | sample col row rgb(hex)
# frames counts vSync falls with the buttons held, the pixel is sampled in the last frame
reset       1  0 0 0   0 3 0   120 50 5c
right10    10  0 1 0   0 3 0    80 84 e0
left20     20  1 0 0   0 3 0    40 84 e0
fire        9  0 0 1   0 3 0    43 48 ff
hit         2  0 0 1   1 3 0    44 44 5c
secondShot  1  0 0 0   1 3 0    43 72 ff
leftClamp  25  1 0 0   2 3 0     7 84 e0
falling    18  0 0 0   2 3 0    72 91 1c
ground      1  0 0 0   2 0 1    72 91 5c
overMove   10  0 1 1   2 0 1     7 84 e0
overFire    1  1 0 1   2 0 1     3 80 5c

// ==== files.f ====
hdl/gamePkg.sv
hdl/pixelTiming.sv
hdl/playerUnit.sv
hdl/birdUnit.sv
hdl/shotUnit.sv
hdl/hitDetect.sv
hdl/objectsMux.sv
hdl/gameController.sv
hdl/gameTop.sv
test/gameTopTb.sv

// ==== Makefile ====
TOP := gameTopTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only -Wall --timing --top-module gameTop -f files.f

clean:
	rm -rf obj_dir

// ==== test/gameTopTb.sv ====
`timescale 1ns/1ps

module gameTopTb;
	import gamePkg::*;

	// status outputs as read at the vSync fall
	typedef struct packed {
		scoreT score;
		heartsT hearts;
		logic over;
	} statusT;

	localparam int TIMEOUT = 2 * int'(H_TOTAL) * int'(V_TOTAL);

	logic clk;
	logic rst;
	logic left;
	logic right;
	logic fire;
	rgbT vgaRgb;
	logic hSync;
	logic vSync;
	logic blankN;
	scoreT score;
	heartsT hearts;
	logic gameOver;

	int errorCount;
	int passCount;
	int failCount;
	int lineCount;
	int dispX;
	int dispY;
	bit framed;
	bit vFell;
	bit hPrev;
	bit vPrev;
	string testName;

	gameTop gameTop_i (.clk(clk), .rst(rst), .left(left), .right(right), .fire(fire),
		.vgaRgb(vgaRgb), .hSync(hSync), .vSync(vSync), .blankN(blankN),
		.score(score), .hearts(hearts), .gameOver(gameOver));

	always #5 clk = !clk;

	// one clock, then rebuild the displayed raster position from the sync edges
	task automatic advance();
		@(posedge clk);
		#1;
		if (vPrev && !vSync) begin
			if (framed) begin
				assert (lineCount == int'(V_TOTAL)) else begin
					$display("Error %s: lines per frame expected %0d actual %0d",
						testName, V_TOTAL, lineCount);
					errorCount++;
				end
			end
			framed = 1'b1;
			vFell = 1'b1;
			lineCount = 0;
			dispX = 0;
			dispY = int'(V_SYNC_START);
		end else begin
			vFell = 1'b0;
			dispX++;
			if (dispX == int'(H_TOTAL)) begin
				dispX = 0;
				dispY = (dispY == int'(V_TOTAL) - 1) ? 0 : dispY + 1;
			end
		end
		if (hPrev && !hSync) begin
			lineCount++;
			dispX = int'(H_SYNC_START);
		end
		hPrev = hSync;
		vPrev = vSync;
	endtask

	task automatic waitVsyncFall(output bit ok);
		int cycles;
		cycles = 0;
		vFell = 1'b0;
		while (!vFell && cycles < TIMEOUT) begin
			advance();
			cycles++;
		end
		ok = vFell;
	endtask

	task automatic waitPixel(input int col, input int row, output bit ok);
		int cycles;
		cycles = 0;
		while (!(dispX == col && dispY == row) && cycles < TIMEOUT) begin
			advance();
			cycles++;
		end
		ok = dispX == col && dispY == row;
	endtask

	task automatic checkPixel(input int col, input int row, input rgbT expected);
		assert (blankN) else begin
			$display("%s: blanking was active at the sampled pixel", testName);
			errorCount++;
		end
		assert (vgaRgb == expected) else begin
			$display("Error %s: rgb at (%0d,%0d) expected %h actual %h",
				testName, col, row, expected, vgaRgb);
			errorCount++;
		end
	endtask

	task automatic checkStatus(input statusT expected);
		assert (score == expected.score) else begin
			$display("Error %s: score expected %0d actual %0d", testName, expected.score, score);
			errorCount++;
		end
		assert (hearts == expected.hearts) else begin
			$display("Error %s: hearts expected %0d actual %0d",
				testName, expected.hearts, hearts);
			errorCount++;
		end
		assert (gameOver == expected.over) else begin
			$display("Error %s: gameOver expected %0d actual %0d",
				testName, expected.over, gameOver);
			errorCount++;
		end
	endtask

	// buttons held for a number of frames, pixel taken in the last frame
	task automatic runTest(input int frames, input bit goLeft, input bit goRight,
		input bit doFire, input statusT expStatus, input int col, input int row,
		input rgbT expRgb, output bit ok);
		int errBefore;
		errBefore = errorCount;
		left = goLeft;
		right = goRight;
		fire = doFire;
		ok = 1'b1;
		for (int n = 1; n < frames && ok; n++) begin
			waitVsyncFall(ok);
		end
		if (ok) begin
			waitPixel(col, row, ok);
		end
		if (ok) begin
			checkPixel(col, row, expRgb);
			waitVsyncFall(ok);
		end
		if (ok) begin
			checkStatus(expStatus);
		end
		if (!ok) begin
			$display("%s: timed out waiting for the raster", testName);
			failCount++;
		end else if (errorCount == errBefore) begin
			$display("%s: ok", testName);
			passCount++;
		end else begin
			$display("%s: failed", testName);
			failCount++;
		end
	endtask

	initial begin
		int fd;
		int code;
		int frames;
		int goLeft;
		int goRight;
		int doFire;
		int expScore;
		int expHearts;
		int expOver;
		int col;
		int row;
		int expRgb;
		string lineText;
		string name;
		bit ok;
		bit stopped;
		statusT expStatus;
		clk = 1'b0;
		rst = 1'b1;
		left = 1'b0;
		right = 1'b0;
		fire = 1'b0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		lineCount = 0;
		dispX = 0;
		dispY = 0;
		framed = 1'b0;
		vFell = 1'b0;
		hPrev = 1'b1;
		vPrev = 1'b1;
		stopped = 1'b0;
		testName = "sync";
		repeat (3) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b0;
		fd = $fopen("test/frames_golden.txt", "r");
		if (fd == 0) begin
			$display("The golden file test/frames_golden.txt could not be opened.");
			failCount++;
		end else begin
			// line up on the end of the first frame
			waitVsyncFall(ok);
			if (!ok) begin
				$display("No vSync fall was seen after reset.");
				failCount++;
				stopped = 1'b1;
			end
			while (!stopped && !$feof(fd)) begin
				code = $fgets(lineText, fd);
				if (code > 1 && lineText.getc(0) != "#") begin
					code = $sscanf(lineText, "%s %d %d %d %d %d %d %d %d %d %h", name, frames,
						goLeft, goRight, doFire, expScore, expHearts, expOver, col, row, expRgb);
					if (code == 11) begin
						testName = name;
						expStatus.score = scoreT'(expScore);
						expStatus.hearts = heartsT'(expHearts);
						expStatus.over = expOver != 0;
						runTest(frames, goLeft != 0, goRight != 0, doFire != 0, expStatus,
							col, row, rgbT'(expRgb), ok);
						stopped = !ok;
					end else begin
						$display("A line of the golden file could not be read: %s", lineText);
						failCount++;
					end
				end
			end
			$fclose(fd);
		end
		$display("%0d tests passed, %0d failed, %0d errors", passCount, failCount, errorCount);
		if (failCount == 0 && passCount > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== hdl/gameTop.sv ====
`timescale 1ns/1ps

module gameTop (
	input logic clk,
	input logic rst,
	input logic left,
	input logic right,
	input logic fire,
	output gamePkg::rgbT vgaRgb,
	output logic hSync,
	output logic vSync,
	output logic blankN,
	output gamePkg::scoreT score,
	output gamePkg::heartsT hearts,
	output logic gameOver
);
	import gamePkg::*;

	pointT pixel;
	pointT playerPos;
	logic startOfFrame;
	logic playerActive;
	drawT playerDraw;
	drawT birdsDraw;
	drawT shotsDraw;
	logic [NUM_OF_BIRDS-1:0] birdsBusReq;
	logic [NUM_OF_BIRDS-1:0] birdGround;
	logic [NUM_OF_BIRDS-1:0] birdAlive;
	logic [NUM_OF_BIRDS-1:0] birdHit;
	logic [NUM_OF_BIRDS-1:0] deployBird;
	logic [NUM_OF_SHOTS-1:0] shotsBusReq;
	logic [NUM_OF_SHOTS-1:0] shotHit;
	logic [NUM_OF_SHOTS-1:0] deployShot;
	logic playerHit;

	assign gameOver = !playerActive;

	pixelTiming pixelTiming_i (.clk(clk), .rst(rst), .pixel(pixel),
		.startOfFrame(startOfFrame), .hSync(hSync), .vSync(vSync), .blankN(blankN));

	playerUnit playerUnit_i (.clk(clk), .rst(rst), .startOfFrame(startOfFrame),
		.left(left), .right(right), .playerActive(playerActive), .pixel(pixel),
		.playerPos(playerPos), .playerDraw(playerDraw));

	birdUnit birdUnit_i (.clk(clk), .rst(rst), .startOfFrame(startOfFrame),
		.deployBird(deployBird), .birdHit(birdHit), .pixel(pixel), .birdsDraw(birdsDraw),
		.birdsBusReq(birdsBusReq), .birdGround(birdGround), .birdAlive(birdAlive));

	shotUnit shotUnit_i (.clk(clk), .rst(rst), .startOfFrame(startOfFrame),
		.deployShot(deployShot), .shotHit(shotHit), .playerPos(playerPos), .pixel(pixel),
		.shotsDraw(shotsDraw), .shotsBusReq(shotsBusReq));

	// pixel-level collisions
	hitDetect hitDetect_i (.clk(clk), .rst(rst), .startOfFrame(startOfFrame),
		.playerReq(playerDraw.req), .birdsBusReq(birdsBusReq), .shotsBusReq(shotsBusReq),
		.birdHit(birdHit), .shotHit(shotHit), .playerHit(playerHit));

	gameController gameController_i (.clk(clk), .rst(rst), .startOfFrame(startOfFrame),
		.fire(fire), .birdHit(birdHit), .birdGround(birdGround), .playerHit(playerHit),
		.birdAlive(birdAlive), .deployBird(deployBird), .deployShot(deployShot),
		.score(score), .hearts(hearts), .playerActive(playerActive));

	objectsMux objectsMux_i (.clk(clk), .rst(rst), .shotsDraw(shotsDraw),
		.birdsDraw(birdsDraw), .playerDraw(playerDraw), .rgb(vgaRgb));

endmodule

// ==== hdl/gameController.sv ====
`timescale 1ns/1ps

module gameController (
	input logic clk,
	input logic rst,
	input logic startOfFrame,
	input logic fire,
	input logic [gamePkg::NUM_OF_BIRDS-1:0] birdHit,
	input logic [gamePkg::NUM_OF_BIRDS-1:0] birdGround,
	input logic playerHit,
	input logic [gamePkg::NUM_OF_BIRDS-1:0] birdAlive,
	output logic [gamePkg::NUM_OF_BIRDS-1:0] deployBird,
	output logic [gamePkg::NUM_OF_SHOTS-1:0] deployShot,
	output gamePkg::scoreT score,
	output gamePkg::heartsT hearts,
	output logic playerActive
);
	import gamePkg::*;

	typedef enum logic {PLAY, OVER} stateT;

	stateT state;
	cooldownT respawnCnt [NUM_OF_BIRDS];
	cooldownT shotCooldown;
	logic [4:0] shotAge [NUM_OF_SHOTS];
	logic [NUM_OF_SHOTS-1:0] shotFree;
	logic [NUM_OF_SHOTS-1:0] launchPick;
	logic launch;
	logic [2:0] hitCount;
	logic [2:0] lossCount;
	logic [8:0] scoreSum;
	heartsT heartsNext;

	always_comb begin
		hitCount = '0;
		lossCount = {2'b0, playerHit};
		for (int i = 0; i < NUM_OF_BIRDS; i++) begin
			hitCount += {2'b0, birdHit[i]};
			lossCount += {2'b0, birdGround[i]};
		end
		// a shot that hit something frees its slot when its flight time ends
		for (int j = 0; j < NUM_OF_SHOTS; j++) begin
			shotFree[j] = shotAge[j] == '0;
		end
	end

	assign scoreSum = {1'b0, score} + {6'b0, hitCount};
	assign heartsNext = (lossCount >= {1'b0, hearts}) ? '0 : hearts - lossCount[1:0];
	// lowest free slot
	assign launchPick = shotFree & (-shotFree);
	assign launch = startOfFrame && state == PLAY && fire && shotCooldown == '0 && |shotFree;
	assign playerActive = state == PLAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= PLAY;
			score <= '0;
			hearts <= START_HEARTS;
		end else if (state == PLAY) begin
			score <= scoreSum[8] ? 8'hff : scoreSum[7:0];
			hearts <= heartsNext;
			if (heartsNext == '0) begin
				state <= OVER;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			deployBird <= '0;
			deployShot <= '0;
			shotCooldown <= '0;
			respawnCnt <= '{default: '0};
			shotAge <= '{default: '0};
		end else begin
			deployBird <= '0;
			deployShot <= launch ? launchPick : '0;
			if (startOfFrame) begin
				for (int i = 0; i < NUM_OF_BIRDS; i++) begin
					if (state == PLAY && !birdAlive[i]) begin
						if (respawnCnt[i] == '0) begin
							deployBird[i] <= 1'b1;
							respawnCnt[i] <= cooldownT'(RESPAWN_FRAMES - 1);
						end else begin
							respawnCnt[i] <= respawnCnt[i] - 4'd1;
						end
					end
				end
				for (int j = 0; j < NUM_OF_SHOTS; j++) begin
					if (launch && launchPick[j]) begin
						shotAge[j] <= 5'(SHOT_FLIGHT);
					end else if (!shotFree[j]) begin
						shotAge[j] <= shotAge[j] - 5'd1;
					end
				end
				if (launch) begin
					shotCooldown <= SHOT_COOLDOWN;
				end else if (shotCooldown != '0) begin
					shotCooldown <= shotCooldown - 4'd1;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) state == PLAY |=> hearts <= $past(hearts));

endmodule

// ==== hdl/objectsMux.sv ====
`timescale 1ns/1ps

module objectsMux (
	input logic clk,
	input logic rst,
	input gamePkg::drawT shotsDraw,
	input gamePkg::drawT birdsDraw,
	input gamePkg::drawT playerDraw,
	output gamePkg::rgbT rgb
);
	import gamePkg::*;

	// shots over birds over player over background
	always_ff @(posedge clk) begin
		if (rst) begin
			rgb <= '0;
		end else if (shotsDraw.req) begin
			rgb <= shotsDraw.rgb;
		end else if (birdsDraw.req) begin
			rgb <= birdsDraw.rgb;
		end else if (playerDraw.req) begin
			rgb <= playerDraw.rgb;
		end else begin
			rgb <= BACKGROUND_RGB;
		end
	end

endmodule

// ==== hdl/hitDetect.sv ====
`timescale 1ns/1ps

module hitDetect (
	input logic clk,
	input logic rst,
	input logic startOfFrame,
	input logic playerReq,
	input logic [gamePkg::NUM_OF_BIRDS-1:0] birdsBusReq,
	input logic [gamePkg::NUM_OF_SHOTS-1:0] shotsBusReq,
	output logic [gamePkg::NUM_OF_BIRDS-1:0] birdHit,
	output logic [gamePkg::NUM_OF_SHOTS-1:0] shotHit,
	output logic playerHit
);
	import gamePkg::*;

	logic [NUM_OF_BIRDS-1:0] birdNow;
	logic [NUM_OF_SHOTS-1:0] shotNow;
	logic playerNow;
	logic [NUM_OF_BIRDS-1:0] birdLatch;
	logic [NUM_OF_SHOTS-1:0] shotLatch;
	logic playerLatch;

	// overlaps on the current pixel
	always_comb begin
		birdNow = '0;
		shotNow = '0;
		for (int i = 0; i < NUM_OF_BIRDS; i++) begin
			for (int j = 0; j < NUM_OF_SHOTS; j++) begin
				if (birdsBusReq[i] && shotsBusReq[j]) begin
					birdNow[i] = 1'b1;
					shotNow[j] = 1'b1;
				end
			end
		end
	end

	assign playerNow = playerReq && |birdsBusReq;

	always_ff @(posedge clk) begin
		if (rst) begin
			birdLatch <= '0;
			shotLatch <= '0;
			playerLatch <= 1'b0;
			birdHit <= '0;
			shotHit <= '0;
			playerHit <= 1'b0;
		end else if (startOfFrame) begin
			// report last frame, start the new one with this pixel
			birdHit <= birdLatch;
			shotHit <= shotLatch;
			playerHit <= playerLatch;
			birdLatch <= birdNow;
			shotLatch <= shotNow;
			playerLatch <= playerNow;
		end else begin
			birdHit <= '0;
			shotHit <= '0;
			playerHit <= 1'b0;
			birdLatch <= birdLatch | birdNow;
			shotLatch <= shotLatch | shotNow;
			playerLatch <= playerLatch | playerNow;
		end
	end

endmodule

// ==== hdl/shotUnit.sv ====
`timescale 1ns/1ps

module shotUnit (
	input logic clk,
	input logic rst,
	input logic startOfFrame,
	input logic [gamePkg::NUM_OF_SHOTS-1:0] deployShot,
	input logic [gamePkg::NUM_OF_SHOTS-1:0] shotHit,
	input gamePkg::pointT playerPos,
	input gamePkg::pointT pixel,
	output gamePkg::drawT shotsDraw,
	output logic [gamePkg::NUM_OF_SHOTS-1:0] shotsBusReq
);
	import gamePkg::*;

	pointT shotPos [NUM_OF_SHOTS];
	logic [NUM_OF_SHOTS-1:0] shotAlive;
	logic [NUM_OF_SHOTS-1:0] leaving;

	always_comb begin
		for (int j = 0; j < NUM_OF_SHOTS; j++) begin
			leaving[j] = shotPos[j].y - SHOT_STEP < 11'sd0;
			shotsBusReq[j] = shotAlive[j]
				&& pixel.x >= shotPos[j].x && pixel.x < shotPos[j].x + SHOT_W
				&& pixel.y >= shotPos[j].y && pixel.y < shotPos[j].y + SHOT_H;
		end
	end

	assign shotsDraw = '{req: |shotsBusReq, rgb: SHOT_RGB};

	always_ff @(posedge clk) begin
		if (rst) begin
			shotAlive <= '0;
		end else begin
			for (int j = 0; j < NUM_OF_SHOTS; j++) begin
				if (deployShot[j]) begin
					shotAlive[j] <= 1'b1;
				end else if (shotHit[j] || (startOfFrame && leaving[j])) begin
					shotAlive[j] <= 1'b0;
				end
			end
		end
	end

	// launch centred just above the player sprite
	always_ff @(posedge clk) begin
		for (int j = 0; j < NUM_OF_SHOTS; j++) begin
			if (deployShot[j]) begin
				shotPos[j].x <= playerPos.x + ((PLAYER_W - SHOT_W) >>> 1);
				shotPos[j].y <= playerPos.y - SHOT_H;
			end else if (startOfFrame && shotAlive[j] && !leaving[j]) begin
				shotPos[j].y <= shotPos[j].y - SHOT_STEP;
			end
		end
	end

endmodule

// ==== hdl/birdUnit.sv ====
`timescale 1ns/1ps

module birdUnit (
	input logic clk,
	input logic rst,
	input logic startOfFrame,
	input logic [gamePkg::NUM_OF_BIRDS-1:0] deployBird,
	input logic [gamePkg::NUM_OF_BIRDS-1:0] birdHit,
	input gamePkg::pointT pixel,
	output gamePkg::drawT birdsDraw,
	output logic [gamePkg::NUM_OF_BIRDS-1:0] birdsBusReq,
	output logic [gamePkg::NUM_OF_BIRDS-1:0] birdGround,
	output logic [gamePkg::NUM_OF_BIRDS-1:0] birdAlive
);
	import gamePkg::*;

	coordT birdY [NUM_OF_BIRDS];
	logic [NUM_OF_BIRDS-1:0] landing;

	always_comb begin
		for (int i = 0; i < NUM_OF_BIRDS; i++) begin
			// bottom row would pass the ground after the next step
			landing[i] = birdY[i] + BIRD_STEP + BIRD_H > GROUND_Y;
			birdsBusReq[i] = birdAlive[i]
				&& pixel.x >= BIRD_COLUMN[i] && pixel.x < BIRD_COLUMN[i] + BIRD_W
				&& pixel.y >= birdY[i] && pixel.y < birdY[i] + BIRD_H;
		end
	end

	assign birdsDraw = '{req: |birdsBusReq, rgb: BIRD_RGB};

	always_ff @(posedge clk) begin
		if (rst) begin
			birdAlive <= '0;
			birdGround <= '0;
		end else begin
			birdGround <= '0;
			for (int i = 0; i < NUM_OF_BIRDS; i++) begin
				if (deployBird[i]) begin
					birdAlive[i] <= 1'b1;
				end else if (birdHit[i]) begin
					birdAlive[i] <= 1'b0;
				end else if (startOfFrame && birdAlive[i] && landing[i]) begin
					birdAlive[i] <= 1'b0;
					birdGround[i] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_OF_BIRDS; i++) begin
			if (deployBird[i]) begin
				birdY[i] <= '0;
			end else if (startOfFrame && birdAlive[i] && !landing[i]) begin
				birdY[i] <= birdY[i] + BIRD_STEP;
			end
		end
	end

	// controller only refills empty slots
	assert property (@(posedge clk) disable iff (rst) (deployBird & birdAlive) == '0);

endmodule

// ==== hdl/playerUnit.sv ====
`timescale 1ns/1ps

module playerUnit (
	input logic clk,
	input logic rst,
	input logic startOfFrame,
	input logic left,
	input logic right,
	input logic playerActive,
	input gamePkg::pointT pixel,
	output gamePkg::pointT playerPos,
	output gamePkg::drawT playerDraw
);
	import gamePkg::*;

	coordT posX;
	coordT leftX;
	coordT rightX;

	// clamped targets for both directions
	always_comb begin
		leftX = posX - PLAYER_STEP;
		rightX = posX + PLAYER_STEP;
		if (leftX < 11'sd0) begin
			leftX = 11'sd0;
		end
		if (rightX > H_VISIBLE - PLAYER_W) begin
			rightX = H_VISIBLE - PLAYER_W;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			posX <= PLAYER_START_X;
		end else if (startOfFrame && playerActive) begin
			if (left && !right) begin
				posX <= leftX;
			end else if (right && !left) begin
				posX <= rightX;
			end
		end
	end

	assign playerPos = '{x: posX, y: PLAYER_Y};

	assign playerDraw.req = pixel.x >= posX && pixel.x < posX + PLAYER_W
		&& pixel.y >= PLAYER_Y && pixel.y < PLAYER_Y + PLAYER_H;
	assign playerDraw.rgb = PLAYER_RGB;

endmodule

// ==== hdl/pixelTiming.sv ====
`timescale 1ns/1ps

module pixelTiming (
	input logic clk,
	input logic rst,
	output gamePkg::pointT pixel,
	output logic startOfFrame,
	output logic hSync,
	output logic vSync,
	output logic blankN
);
	import gamePkg::*;

	coordT hCount;
	coordT vCount;
	logic lineEnd;

	assign lineEnd = hCount == H_TOTAL - 11'sd1;
	assign pixel = '{x: hCount, y: vCount};
	assign startOfFrame = hCount == 11'sd0 && vCount == 11'sd0;

	always_ff @(posedge clk) begin
		if (rst) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			hCount <= lineEnd ? 11'sd0 : hCount + 11'sd1;
			if (lineEnd) begin
				vCount <= (vCount == V_TOTAL - 11'sd1) ? 11'sd0 : vCount + 11'sd1;
			end
		end
	end

	// one cycle behind pixel, same as the mux output
	always_ff @(posedge clk) begin
		if (rst) begin
			hSync <= 1'b1;
			vSync <= 1'b1;
			blankN <= 1'b0;
		end else begin
			hSync <= !(hCount >= H_SYNC_START && hCount < H_SYNC_END);
			vSync <= !(vCount >= V_SYNC_START && vCount < V_SYNC_END);
			blankN <= hCount < H_VISIBLE && vCount < V_VISIBLE;
		end
	end

	// frame start is a single-cycle strobe
	assert property (@(posedge clk) disable iff (rst) startOfFrame |=> !startOfFrame);

endmodule

// ==== hdl/gamePkg.sv ====
package gamePkg;

	typedef logic signed [10:0] coordT;
	typedef logic [7:0] rgbT;
	typedef logic [7:0] scoreT;
	typedef logic [1:0] heartsT;
	typedef logic [3:0] cooldownT;

	typedef struct packed {
		coordT x;
		coordT y;
	} pointT;

	// one draw request with its colour
	typedef struct packed {
		logic req;
		rgbT rgb;
	} drawT;

	// raster
	localparam coordT H_VISIBLE = 11'sd128;
	localparam coordT H_TOTAL = 11'sd160;
	localparam coordT V_VISIBLE = 11'sd96;
	localparam coordT V_TOTAL = 11'sd104;
	localparam coordT H_SYNC_START = 11'sd136;
	localparam coordT H_SYNC_END = 11'sd148;
	localparam coordT V_SYNC_START = 11'sd98;
	localparam coordT V_SYNC_END = 11'sd100;

	localparam int NUM_OF_BIRDS = 4;
	localparam int NUM_OF_SHOTS = 2;

	localparam coordT PLAYER_Y = 11'sd84;
	localparam coordT PLAYER_W = 11'sd8;
	localparam coordT PLAYER_H = 11'sd8;
	localparam coordT PLAYER_START_X = 11'sd60;
	localparam coordT PLAYER_STEP = 11'sd2;

	localparam coordT BIRD_W = 11'sd8;
	localparam coordT BIRD_H = 11'sd6;
	localparam coordT BIRD_COLUMN [NUM_OF_BIRDS] = '{11'sd8, 11'sd40, 11'sd72, 11'sd104};
	localparam coordT BIRD_STEP = 11'sd1;
	localparam coordT GROUND_Y = 11'sd92;

	localparam coordT SHOT_W = 11'sd2;
	localparam coordT SHOT_H = 11'sd4;
	localparam coordT SHOT_STEP = 11'sd4;
	localparam cooldownT SHOT_COOLDOWN = 4'd8;
	// frames from launch until a shot leaves the top row
	localparam int SHOT_FLIGHT = int'((PLAYER_Y - SHOT_H) / SHOT_STEP) + 1;

	localparam heartsT START_HEARTS = 2'd3;
	localparam int RESPAWN_FRAMES = 16;

	localparam rgbT BACKGROUND_RGB = 8'h5c;
	localparam rgbT PLAYER_RGB = 8'he0;
	localparam rgbT BIRD_RGB = 8'h1c;
	localparam rgbT SHOT_RGB = 8'hff;

endpackage
